// File: Makefile
# Verilator flow for the operand decode stage
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module decodeStage
	verilator --lint-only --timing -f src.f --top-module tb_decodeStage

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_decodeStage -Mdir obj_dir
	./obj_dir/Vtb_decodeStage | tee $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: decodeClass.sv
// Instruction class and immediate decoder
// Flags loads, stores and control transfers, and sign extends the immediate
// of each format to the full data width
`timescale 1ns/100ps
`include "decode_defs.svh"

module decodeClass
	import decodePkg::*;
(
	input  instr_t              instr,
	output logic                isLoad,
	output logic                isStore,
	output logic                isBranch,
	output logic [`DATA_W-1:0]  imm
);

	// Lowest bit of each immediate, the field always runs up to the top bit
	localparam int unsigned immRiLo = 18;
	localparam int unsigned immBrLo = 24;
	localparam int unsigned immJmpLo = 8;

	// Branch displacements count words, so they are shifted by this much
	localparam int unsigned dispShift = 2;

	opcode_t opc;

	assign opc = opcOf(instr);

	// Arithmetic shift of the whole word sign extends the upper field in one step
	function automatic logic [`DATA_W-1:0] sextHigh(instr_t ir, int unsigned lo);
		logic signed [`INSTR_W-1:0] s;
		s = $signed(ir) >>> lo;
		return {{(`DATA_W-`INSTR_W){s[`INSTR_W-1]}}, s};
	endfunction

	always_comb
	begin
		isLoad = 1'b0;
		isStore = 1'b0;
		isBranch = 1'b0;
		imm = '0;
		case (opc)
			OP_ADDI, OP_ANDI, OP_ORI, OP_CMPI:
				imm = sextHigh(instr, immRiLo);
			OP_LD:
			begin
				isLoad = 1'b1;
				imm = sextHigh(instr, immRiLo);
			end
			// Store offset sits above the data register field
			OP_ST:
			begin
				isStore = 1'b1;
				imm = sextHigh(instr, immBrLo);
			end
			OP_BEQ, OP_BNE, OP_DBNE:
			begin
				isBranch = 1'b1;
				imm = sextHigh(instr, immBrLo) << dispShift;
			end
			// Long displacement overlays the unused upper target bits
			OP_JSR, OP_BSR:
			begin
				isBranch = 1'b1;
				imm = sextHigh(instr, immJmpLo) << dispShift;
			end
			// Return pops the stack so it has no immediate
			OP_RTD:
				isBranch = 1'b1;
			default:
				imm = '0;
		endcase
		// Later stages steer by class, so the groups must never overlap
		assert ($onehot0({isLoad, isStore, isBranch}))
		else
			$error("decodeClass: more than one class flag for opcode %0d", opc);
	end

endmodule

// File: decodePkg.sv
// Shared types for the operand decode stage
// Holds the opcode map, register and mode types and the decoded result record,
// plus the small field helpers that every decoder needs
`include "decode_defs.svh"

package decodePkg;

	// ==================================================
	// Basic types
	// ==================================================

	typedef logic [`INSTR_W-1:0] instr_t;
	typedef logic [`AREG_W-1:0] aregno_t;

	// The mode also selects which banked stack pointer register 31 refers to
	typedef enum logic [1:0]
	{
		OM_USER    = 2'd0,
		OM_SUPER   = 2'd1,
		OM_HYPER   = 2'd2,
		OM_MACHINE = 2'd3
	} opMode_t;

	// Reduced opcode map, zero is kept free for NOP so a cleared word is harmless
	typedef enum logic [`OPC_HI-`OPC_LO:0]
	{
		OP_NOP  = 6'd0,
		OP_ADD  = 6'd1,
		OP_SUB  = 6'd2,
		OP_AND  = 6'd3,
		OP_OR   = 6'd4,
		OP_MOV  = 6'd5,
		OP_ADDI = 6'd6,
		OP_ANDI = 6'd7,
		OP_ORI  = 6'd8,
		OP_CMPI = 6'd9,
		OP_LD   = 6'd10,
		OP_ST   = 6'd11,
		OP_BEQ  = 6'd12,
		OP_BNE  = 6'd13,
		OP_DBNE = 6'd14,
		OP_JSR  = 6'd15,
		OP_BSR  = 6'd16,
		OP_RTD  = 6'd17
	} opcode_t;

	// Everything the rename stage needs from one instruction
	typedef struct packed
	{
		aregno_t             rt;
		logic                rtz;
		logic                rtn;
		aregno_t             ra;
		logic                ran;
		aregno_t             rb;
		logic                rbn;
		logic                rbUsed;
		logic                isLoad;
		logic                isStore;
		logic                isBranch;
		logic [`DATA_W-1:0]  imm;
	} decodedInstr_t;

	// ==================================================
	// Field helpers
	// ==================================================

	function automatic opcode_t opcOf(instr_t ir);
		return opcode_t'(ir[`OPC_HI:`OPC_LO]);
	endfunction

	// Register number of the field starting at lo, negate bit stripped off
	function automatic aregno_t fieldNum(instr_t ir, int unsigned lo);
		return aregno_t'(ir[lo +: `AREG_W-1]);
	endfunction

	function automatic logic fieldNeg(instr_t ir, int unsigned lo);
		return ir[lo + `AREG_W - 1];
	endfunction

	// Register 31 becomes the stack pointer of the current mode
	function automatic aregno_t spRemap(aregno_t r, opMode_t om);
		return (r == aregno_t'(`SP_REG)) ? aregno_t'(`SP_BANK) + aregno_t'(om) : r;
	endfunction

endpackage

// File: decodeRt.sv
// Target register decoder
// Picks the destination register from the instruction format, applies the
// banked stack pointer remap and reports the zero and negate flags
`timescale 1ns/100ps
`include "decode_defs.svh"

module decodeRt
	import decodePkg::*;
(
	input  instr_t   instr,
	input  opMode_t  om,
	output aregno_t  rt,
	output logic     rtz,
	output logic     rtn
);

	opcode_t    opc;
	aregno_t    rtSel;
	logic       negSel;
	logic       rawSp;
	logic [1:0] linkSel;

	assign opc = opcOf(instr);

	// BSR reuses the low two bits of the target field as a link selector
	assign linkSel = instr[`RT_LO +: 2];

	// Only MOV may name the raw stack pointer, everyone else gets the bank
	assign rawSp = (opc == OP_MOV) && instr[`RAWSP_BIT];

	// ==================================================
	// Target selection by format
	// ==================================================
	always_comb
	begin
		rtSel = '0;
		negSel = 1'b0;
		case (opc)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_MOV,
			OP_ADDI, OP_ANDI, OP_ORI, OP_CMPI:
			begin
				rtSel = fieldNum(instr, `RT_LO);
				negSel = fieldNeg(instr, `RT_LO);
			end
			// Loads and jumps write their target but never negate it
			OP_LD, OP_JSR:
				rtSel = fieldNum(instr, `RT_LO);
			// Decrement and branch writes back the counter it tested
			OP_DBNE:
				rtSel = fieldNum(instr, `RA_LO);
			OP_RTD:
				rtSel = aregno_t'(`SP_REG);
			// Selector zero means no link register is written
			OP_BSR:
			begin
				if (linkSel != 2'b00)
					rtSel = aregno_t'(`LINK_BASE) + aregno_t'(linkSel);
			end
			default:
				rtSel = '0;
		endcase
		// Register zero is hard wired so a negate flag on it has no meaning
		negSel = negSel && (rtSel != '0);
	end

	// ==================================================
	// Stack pointer bank and flags
	// ==================================================
	always_comb
	begin
		rt = rawSp ? rtSel : spRemap(rtSel, om);
		rtz = (rt == '0);
		rtn = negSel;
		// The bank remap must never turn a live target into register zero
		assert (!(rtz && rtn))
		else
			$error("decodeRt: zero target flagged as negated, opcode %0d", opc);
	end

endmodule

// File: decodeSrc.sv
// Source register decoder
// Extracts both source registers with their negate bits, maps register 31 to
// the banked stack pointer and tells whether the second source is read
`timescale 1ns/100ps
`include "decode_defs.svh"

module decodeSrc
	import decodePkg::*;
(
	input  instr_t   instr,
	input  opMode_t  om,
	output aregno_t  ra,
	output logic     ran,
	output aregno_t  rb,
	output logic     rbn,
	output logic     rbUsed
);

	opcode_t opc;
	aregno_t raSel;
	aregno_t rbSel;

	assign opc = opcOf(instr);

	always_comb
	begin
		raSel = '0;
		rbSel = '0;
		ran = 1'b0;
		rbn = 1'b0;
		rbUsed = 1'b0;
		case (opc)
			// Three register formats are the only ones that carry negate bits
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_MOV:
			begin
				raSel = fieldNum(instr, `RA_LO);
				ran = fieldNeg(instr, `RA_LO);
				rbSel = fieldNum(instr, `RB_LO);
				rbn = fieldNeg(instr, `RB_LO);
				rbUsed = 1'b1;
			end
			// Stores and compare branches read two registers without negation
			OP_ST, OP_BEQ, OP_BNE:
			begin
				raSel = fieldNum(instr, `RA_LO);
				rbSel = fieldNum(instr, `RB_LO);
				rbUsed = 1'b1;
			end
			// Immediate forms keep the second source field for immediate bits
			OP_ADDI, OP_ANDI, OP_ORI, OP_CMPI,
			OP_LD, OP_DBNE, OP_RTD:
				raSel = fieldNum(instr, `RA_LO);
			// JSR, BSR and NOP read no register
			default:
				raSel = '0;
		endcase
	end

	// Sources always follow the bank, there is no raw form on the read side
	assign ra = spRemap(raSel, om);
	assign rb = spRemap(rbSel, om);

endmodule

// File: decodeStage.sv
// Operand register decode stage
// Decodes one instruction per cycle into target, sources, class and immediate,
// and hands the result downstream through a skid register
`timescale 1ns/100ps
`include "decode_defs.svh"

module decodeStage
	import decodePkg::*;
(
	input  logic                clk,
	input  logic                rstN,
	input  logic                instrValid,
	output logic                instrReady,
	input  instr_t              instr,
	input  opMode_t             om,
	output logic                outValid,
	input  logic                outReady,
	output aregno_t             rt,
	output logic                rtz,
	output logic                rtn,
	output aregno_t             ra,
	output logic                ran,
	output aregno_t             rb,
	output logic                rbn,
	output logic                rbUsed,
	output logic                isLoad,
	output logic                isStore,
	output logic                isBranch,
	output logic [`DATA_W-1:0]  imm
);

	decodedInstr_t decIn;
	decodedInstr_t decOut;

	// ==================================================
	// Combinational decoders write straight into the record
	// ==================================================
	decodeRt rt_i (
		.instr (instr),
		.om    (om),
		.rt    (decIn.rt),
		.rtz   (decIn.rtz),
		.rtn   (decIn.rtn)
	);

	decodeSrc src_i (
		.instr  (instr),
		.om     (om),
		.ra     (decIn.ra),
		.ran    (decIn.ran),
		.rb     (decIn.rb),
		.rbn    (decIn.rbn),
		.rbUsed (decIn.rbUsed)
	);

	decodeClass class_i (
		.instr    (instr),
		.isLoad   (decIn.isLoad),
		.isStore  (decIn.isStore),
		.isBranch (decIn.isBranch),
		.imm      (decIn.imm)
	);

	// Mode is sampled with the instruction, so only the decoded record is stored
	pipeSkid #(
		.T (decodedInstr_t)
	) skid_i (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (instrValid),
		.inReady  (instrReady),
		.inData   (decIn),
		.outValid (outValid),
		.outReady (outReady),
		.outData  (decOut)
	);

	// Record fields fan back out to the loose output ports
	assign rt = decOut.rt;
	assign rtz = decOut.rtz;
	assign rtn = decOut.rtn;
	assign ra = decOut.ra;
	assign ran = decOut.ran;
	assign rb = decOut.rb;
	assign rbn = decOut.rbn;
	assign rbUsed = decOut.rbUsed;
	assign isLoad = decOut.isLoad;
	assign isStore = decOut.isStore;
	assign isBranch = decOut.isBranch;
	assign imm = decOut.imm;

endmodule

// File: decode_defs.svh
// Instruction word layout and fixed register numbers for the operand decode stage
// Include this wherever the instruction word is sliced or a fixed register is named
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Datapath widths
`define INSTR_W     32
`define AREG_W      6
`define DATA_W      64

// Opcode sits in the lowest six bits of every format
`define OPC_LO      0
`define OPC_HI      5

// Register fields are six bits wide, negate flag on top and number below
`define RT_LO       6
`define RA_LO       12
`define RB_LO       18

// MOV uses the top bit to address the unbanked stack pointer
`define RAWSP_BIT   31

// Register 31 names the stack pointer, banked by mode from register 32 on
`define SP_REG      31
`define SP_BANK     32
`define LINK_BASE   40

`endif

// File: pipeSkid.sv
// Two entry skid register for a valid/ready pipeline
// Accepts one item per cycle with a ready that comes straight from a flop,
// the second entry catches the item in flight when the output stalls
`timescale 1ns/100ps

module pipeSkid #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	output logic inReady,
	input  T     inData,
	output logic outValid,
	input  logic outReady,
	output T     outData
);

	T     skidData;
	logic mainFree;
	logic loadFromSkid;
	logic loadFromIn;
	logic loadSkid;

	// The main entry can be refilled when it is empty or drains this cycle
	assign mainFree = !outValid || outReady;

	// Ready low means the skid entry is full, and it always drains first
	assign loadFromSkid = mainFree && !inReady;
	assign loadFromIn = mainFree && inReady && inValid;
	assign loadSkid = !mainFree && inReady && inValid;

	// ==================================================
	// Control state
	// ==================================================
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
			inReady <= 1'b1;
		end
		else
		begin
			if (mainFree)
				outValid <= loadFromSkid || loadFromIn;
			if (loadFromSkid)
				inReady <= 1'b1;
			else if (loadSkid)
				inReady <= 1'b0;
		end
	end

	// Payload entries
	always_ff @(posedge clk)
	begin
		if (loadFromSkid)
			outData <= skidData;
		else if (loadFromIn)
			outData <= inData;
		if (loadSkid)
			skidData <= inData;
	end

	// A stalled output must present the same item on the next cycle
	assert property (@(posedge clk) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outData));

	// While ready is low the waiting item in the skid entry is never overwritten
	assert property (@(posedge clk) disable iff (!rstN)
		!inReady |=> $stable(skidData));

endmodule

// File: src.f
+incdir+.
decodePkg.sv
decodeRt.sv
decodeSrc.sv
decodeClass.sv
pipeSkid.sv
decodeStage.sv
tb_decodeStage.sv

// File: tb_decodeStage.sv
// Testbench for the operand decode stage
// Sends random instructions under random output stalls, predicts every decoded
// record with an independent model and scores the outputs in order
`timescale 1ns/100ps
`include "decode_defs.svh"

module tb_decodeStage
	import decodePkg::*;
();

	localparam int unsigned targetCount = 18 * 4 * 4;
	localparam int unsigned randomCount = 200;
	localparam int unsigned stallCount = 200;
	localparam int unsigned burstCount = 100;
	localparam int unsigned cycleLimit =
		4 * (targetCount + randomCount + stallCount + burstCount) + 200;

	logic clk;
	logic rstN;
	logic instrValid;
	logic instrReady;
	instr_t instr;
	opMode_t om;
	logic outValid;
	logic outReady;
	aregno_t rt;
	logic rtz;
	logic rtn;
	aregno_t ra;
	logic ran;
	aregno_t rb;
	logic rbn;
	logic rbUsed;
	logic isLoad;
	logic isStore;
	logic isBranch;
	logic [`DATA_W-1:0] imm;

	// Expected records in acceptance order, and the stimulus of the running test
	decodedInstr_t expQ[$];
	logic [33:0] stimQ[$];

	int unsigned cycle;
	int unsigned outCount;
	int unsigned batchBase;
	int unsigned firstOutCycle;
	int unsigned lastOutCycle;
	int unsigned errCount;
	int unsigned checkCount;
	int unsigned seqErrCount;
	int unsigned seqCheckCount;
	int unsigned markErr;
	int unsigned markChecks;
	logic stallPrev;
	decodedInstr_t heldOut;

	decodeStage dut_i (
		.clk(clk), .rstN(rstN), .instrValid(instrValid), .instrReady(instrReady),
		.instr(instr), .om(om), .outValid(outValid), .outReady(outReady),
		.rt(rt), .rtz(rtz), .rtn(rtn), .ra(ra), .ran(ran), .rb(rb), .rbn(rbn),
		.rbUsed(rbUsed), .isLoad(isLoad), .isStore(isStore), .isBranch(isBranch),
		.imm(imm)
	);

	always #20 clk = ~clk;

	// ==================================================
	// Model of the decode rules
	// ==================================================
	function automatic decodedInstr_t refDecode(input logic [31:0] ir, input logic [1:0] mode);
		decodedInstr_t d;
		opcode_t opc;
		logic threeReg;
		logic immOp;
		logic known;
		d = '0;
		opc = opcode_t'(ir[5:0]);
		known = (ir[5:0] <= 6'd17);
		threeReg = opc inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_MOV};
		immOp = opc inside {OP_ADDI, OP_ANDI, OP_ORI, OP_CMPI};
		// Target register
		if (threeReg || immOp)
		begin
			d.rt = {1'b0, ir[10:6]};
			d.rtn = ir[11];
		end
		else if (opc == OP_LD || opc == OP_JSR)
			d.rt = {1'b0, ir[10:6]};
		else if (opc == OP_DBNE)
			d.rt = {1'b0, ir[16:12]};
		else if (opc == OP_RTD)
			d.rt = 6'd31;
		else if (opc == OP_BSR && ir[7:6] != 2'b00)
			d.rt = 6'd40 + {4'b0000, ir[7:6]};
		// MOV with the top bit set writes the unbanked stack pointer
		if (d.rt == 6'd31 && !(opc == OP_MOV && ir[31]))
			d.rt = 6'd32 + {4'b0000, mode};
		if (d.rt == 6'd0)
			d.rtn = 1'b0;
		d.rtz = (d.rt == 6'd0);
		// Source registers
		if (known && !(opc inside {OP_JSR, OP_BSR, OP_NOP}))
			d.ra = {1'b0, ir[16:12]};
		if (threeReg || opc inside {OP_ST, OP_BEQ, OP_BNE})
		begin
			d.rb = {1'b0, ir[22:18]};
			d.rbUsed = 1'b1;
		end
		if (threeReg)
		begin
			d.ran = ir[17];
			d.rbn = ir[23];
		end
		if (d.ra == 6'd31)
			d.ra = 6'd32 + {4'b0000, mode};
		if (d.rb == 6'd31)
			d.rb = 6'd32 + {4'b0000, mode};
		// Class flags and immediate formats
		d.isLoad = (opc == OP_LD);
		d.isStore = (opc == OP_ST);
		d.isBranch = opc inside {OP_BEQ, OP_BNE, OP_DBNE, OP_JSR, OP_BSR, OP_RTD};
		if (immOp || opc == OP_LD)
			d.imm = {{50{ir[31]}}, ir[31:18]};
		else if (opc == OP_ST)
			d.imm = {{56{ir[31]}}, ir[31:24]};
		else if (opc inside {OP_BEQ, OP_BNE, OP_DBNE})
			d.imm = {{54{ir[31]}}, ir[31:24], 2'b00};
		else if (opc inside {OP_JSR, OP_BSR})
			d.imm = {{38{ir[31]}}, ir[31:8], 2'b00};
		return d;
	endfunction

	function automatic decodedInstr_t packOut();
		return {rt, rtz, rtn, ra, ran, rb, rbn, rbUsed, isLoad, isStore, isBranch, imm};
	endfunction

	task automatic checkField(input string name, input logic [63:0] expVal,
		input logic [63:0] actVal);
		checkCount++;
		assert (actVal === expVal)
		else
		begin
			$display("ERROR %s: expected %h, got %h", name, expVal, actVal);
			errCount++;
		end
	endtask

	task automatic compareRecord(input decodedInstr_t e, input decodedInstr_t a);
		checkField("rt", 64'(e.rt), 64'(a.rt));
		checkField("rtz", 64'(e.rtz), 64'(a.rtz));
		checkField("rtn", 64'(e.rtn), 64'(a.rtn));
		checkField("ra", 64'(e.ra), 64'(a.ra));
		checkField("ran", 64'(e.ran), 64'(a.ran));
		checkField("rb", 64'(e.rb), 64'(a.rb));
		checkField("rbn", 64'(e.rbn), 64'(a.rbn));
		checkField("rbUsed", 64'(e.rbUsed), 64'(a.rbUsed));
		checkField("isLoad", 64'(e.isLoad), 64'(a.isLoad));
		checkField("isStore", 64'(e.isStore), 64'(a.isStore));
		checkField("isBranch", 64'(e.isBranch), 64'(a.isBranch));
		checkField("imm", e.imm, a.imm);
	endtask

	// ==================================================
	// Scoreboard and cycle limit
	// ==================================================
	always @(posedge clk)
	begin
		if (!rstN)
			stallPrev = 1'b0;
		else
		begin
			// A stall seen at the last edge must leave the same item on the outputs
			if (stallPrev)
			begin
				checkCount++;
				assert (outValid && packOut() === heldOut)
				else
				begin
					$display("ERROR held outputs: expected %h, got %h, outValid %h",
						heldOut, packOut(), outValid);
					errCount++;
				end
			end
			stallPrev = outValid && !outReady;
			heldOut = packOut();
			if (instrValid && instrReady)
				expQ.push_back(refDecode(instr, om));
			if (outValid && outReady)
			begin
				if (expQ.size() == 0)
				begin
					$display("Output transfer with no instruction outstanding");
					errCount++;
				end
				else
					compareRecord(expQ.pop_front(), packOut());
				if (outCount == batchBase)
					firstOutCycle = cycle;
				lastOutCycle = cycle;
				outCount++;
			end
		end
		cycle++;
		if (cycle > cycleLimit)
		begin
			$display("Timeout after %0d cycles with outputs still outstanding", cycleLimit);
			$display("** FAIL **");
			$finish;
		end
	end

	// Drives the queued stimulus, stalling the output stallPct percent of cycles,
	// then waits until every accepted item has left the stage
	task automatic sendAll(input int unsigned stallPct);
		int unsigned sent;
		sent = 0;
		batchBase = outCount;
		while (sent < stimQ.size())
		begin
			instrValid <= 1'b1;
			instr <= stimQ[sent][31:0];
			om <= opMode_t'(stimQ[sent][33:32]);
			outReady <= ($urandom_range(99) >= stallPct);
			@(posedge clk);
			if (instrReady)
				sent++;
		end
		instrValid <= 1'b0;
		outReady <= 1'b1;
		while (outCount < batchBase + stimQ.size())
			@(negedge clk);
		@(posedge clk);
	endtask

	task automatic queueRandom(input int unsigned count);
		logic [31:0] ir;
		for (int unsigned i = 0; i < count; i++)
		begin
			ir = $urandom();
			ir[5:0] = 6'($urandom_range(17));
			stimQ.push_back({2'($urandom_range(3)), ir});
		end
	endtask

	task automatic reportTest(input int unsigned num, input string name);
		int unsigned errs;
		int unsigned checks;
		errs = errCount + seqErrCount - markErr;
		checks = checkCount + seqCheckCount - markChecks;
		$display("Test %0d %s: %0d checks, %0d errors", num, name, checks, errs);
		markErr = errCount + seqErrCount;
		markChecks = checkCount + seqCheckCount;
		stimQ.delete();
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial
	begin
		logic [31:0] ir;
		void'($urandom(32'h460962e2));
		clk = 1'b0;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		om = OM_USER;
		outReady = 1'b0;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		@(posedge clk);

		seqCheckCount++;
		assert (!outValid && instrReady)
		else
		begin
			$display("ERROR outValid/instrReady after reset: expected 0/1, got %h/%h",
				outValid, instrReady);
			seqErrCount++;
		end
		reportTest(1, "reset state");
		outReady <= 1'b1;

		// Every opcode in every mode, with fields forced onto the stack pointer,
		// the MOV raw bit and each BSR selector
		for (int o = 0; o <= 17; o++)
			for (int m = 0; m < 4; m++)
				for (int v = 0; v < 4; v++)
				begin
					ir = $urandom();
					ir[5:0] = 6'(o);
					case (v)
						1:
						begin
							ir[10:6] = 5'h1f;
							ir[31] = 1'b0;
						end
						2:
						begin
							ir[10:6] = 5'h1f;
							ir[16:12] = 5'h1f;
							ir[31] = 1'b1;
						end
						// Negated target whose number is the mode, so mode 0 names register zero
						3:
						begin
							ir[11:6] = {1'b1, 3'b000, 2'(m)};
							ir[22:18] = 5'h1f;
						end
						default:
							ir[31] = ir[30];
					endcase
					stimQ.push_back({2'(m), ir});
				end
		sendAll(0);
		reportTest(2, "target decode");

		queueRandom(randomCount);
		sendAll(20);
		reportTest(3, "sources and class");

		queueRandom(stallCount);
		sendAll(50);
		reportTest(4, "back-pressure");

		queueRandom(burstCount);
		sendAll(0);
		seqCheckCount++;
		assert (lastOutCycle - firstOutCycle == burstCount - 1)
		else
		begin
			$display("Burst of %0d outputs took %0d cycles, so the output had bubbles",
				burstCount, lastOutCycle - firstOutCycle + 1);
			seqErrCount++;
		end
		reportTest(5, "throughput");

		$display("Summary: 5 tests, %0d checks, %0d errors",
			checkCount + seqCheckCount, errCount + seqErrCount);
		if (errCount + seqErrCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
